//--- design/alu.sv
`timescale 1ns/10ps

module alu
	import cpu_pkg::*;
	import isa_pkg::*;
(
	input  logic [alu_op_w-1:0]    op,   // operation select
	input  logic [word_data_w-1:0] in_0, // operand a
	input  logic [word_data_w-1:0] in_1, // operand b
	output logic [word_data_w-1:0] out,  // result
	output logic                   of    // signed overflow
);

	logic [alu_shamt_w-1:0] shamt;
	logic [word_data_w-1:0] sum;
	logic [word_data_w-1:0] diff;
	logic                   add_of;
	logic                   sub_of;

	assign shamt = in_1[alu_shamt_w-1:0]; // upper bits of b ignored
	assign sum   = in_0 + in_1;
	assign diff  = in_0 - in_1;

	// add overflows when both operands share a sign the result lacks
	assign add_of = (in_0[word_msb] == in_1[word_msb]) &&
		(sum[word_msb] != in_0[word_msb]);

	// sub overflows when the signs differ and the result follows b
	assign sub_of = (in_0[word_msb] != in_1[word_msb]) &&
		(diff[word_msb] != in_0[word_msb]);

	always_comb begin
		out = word_data_zero; // unknown ops give zero
		of  = 1'b0;
		case (op)
			alu_op_nop: begin
				out = in_0;
			end
			alu_op_and: begin
				out = in_0 & in_1;
			end
			alu_op_or: begin
				out = in_0 | in_1;
			end
			alu_op_xor: begin
				out = in_0 ^ in_1;
			end
			alu_op_adds: begin
				out = sum;
				of  = add_of;
			end
			alu_op_addu: begin
				out = sum; // wraps, never flags
			end
			alu_op_subs: begin
				out = diff;
				of  = sub_of;
			end
			alu_op_subu: begin
				out = diff;
			end
			alu_op_shrl: begin
				out = in_0 >> shamt;
			end
			alu_op_shll: begin
				out = in_0 << shamt;
			end
			alu_op_shra: begin
				out = $signed(in_0) >>> shamt; // sign fill
			end
			default: begin
				out = word_data_zero;
			end
		endcase

		// ex_reg turns of into an exception, so a stray flag would trap
		// unsigned or logic ops in the next stage
		assert (!of || op == alu_op_adds || op == alu_op_subs)
			else $error("alu: overflow flagged for op %0h", op);
	end

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

	// bus widths
	localparam int word_data_w = 32; // data word
	localparam int word_addr_w = 30; // pc counts words, not bytes
	localparam int reg_addr_w  = 5;  // 32 gprs

	localparam int word_msb = word_data_w - 1; // sign bit position

	// idle values of pipeline register fields
	localparam logic [word_data_w-1:0] word_data_zero = '0;
	localparam logic [word_addr_w-1:0] word_addr_zero = '0;
	localparam logic [reg_addr_w-1:0]  reg_addr_zero  = '0;

	localparam logic slot_dis   = 1'b0; // slot holds no instruction
	localparam logic br_none    = 1'b0; // no branch taken
	localparam logic gpr_we_off = 1'b1; // write enable is active low

endpackage

//--- design/ex_reg.sv
`timescale 1ns/10ps

module ex_reg
	import cpu_pkg::*;
	import isa_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	// alu result
	input  logic [word_data_w-1:0] alu_out,
	input  logic                   alu_of,
	// pipeline control
	input  logic                   stall,
	input  logic                   flush,
	input  logic                   int_detect,
	// id/ex fields
	input  logic [word_addr_w-1:0] id_pc,
	input  logic                   id_en,
	input  logic                   id_br_flag,
	input  logic [mem_op_w-1:0]    id_mem_op,
	input  logic [word_data_w-1:0] id_mem_wr_data,
	input  logic [ctrl_op_w-1:0]   id_ctrl_op,
	input  logic [reg_addr_w-1:0]  id_dst_addr,
	input  logic                   id_gpr_we_,
	input  logic [isa_exp_w-1:0]   id_exp_code,
	// ex/mem fields
	output logic [word_addr_w-1:0] ex_pc,
	output logic                   ex_en,
	output logic                   ex_br_flag,
	output logic [mem_op_w-1:0]    ex_mem_op,
	output logic [word_data_w-1:0] ex_mem_wr_data,
	output logic [ctrl_op_w-1:0]   ex_ctrl_op,
	output logic [reg_addr_w-1:0]  ex_dst_addr,
	output logic                   ex_gpr_we_,
	output logic [isa_exp_w-1:0]   ex_exp_code,
	output logic [word_data_w-1:0] ex_out
);

	logic take_exp; // slot becomes an exception

	assign take_exp = int_detect || alu_of;

	always_ff @(posedge clk) begin
		if (!rst_n || (!stall && flush)) begin // flush looks like reset
			ex_pc          <= word_addr_zero;
			ex_en          <= slot_dis;
			ex_br_flag     <= br_none;
			ex_mem_op      <= mem_op_nop;
			ex_mem_wr_data <= word_data_zero;
			ex_ctrl_op     <= ctrl_op_nop;
			ex_dst_addr    <= reg_addr_zero;
			ex_gpr_we_     <= gpr_we_off;
			ex_exp_code    <= isa_exp_no_exp;
			ex_out         <= word_data_zero;
		end else if (!stall) begin
			ex_pc      <= id_pc; // kept for the handler's return address
			ex_en      <= id_en;
			ex_br_flag <= id_br_flag;
			if (take_exp) begin
				// squash side effects, interrupt beats overflow
				ex_mem_op      <= mem_op_nop;
				ex_mem_wr_data <= word_data_zero;
				ex_ctrl_op     <= ctrl_op_nop;
				ex_dst_addr    <= reg_addr_zero;
				ex_gpr_we_     <= gpr_we_off;
				ex_exp_code    <= int_detect ? isa_exp_ext_int : isa_exp_overflow;
				ex_out         <= word_data_zero;
			end else begin
				ex_mem_op      <= id_mem_op;
				ex_mem_wr_data <= id_mem_wr_data;
				ex_ctrl_op     <= id_ctrl_op;
				ex_dst_addr    <= id_dst_addr;
				ex_gpr_we_     <= id_gpr_we_;
				ex_exp_code    <= id_exp_code; // earlier stage codes ride along
				ex_out         <= alu_out;
			end
		end
	end

	// a flushed slot never reaches mem as a live instruction
	ap_flush_kills_slot: assert property (@(posedge clk) disable iff (!rst_n)
		(!stall && flush) |=> !ex_en)
		else $error("ex_reg: slot still enabled after flush");

	// an excepted slot must not write memory or the register file
	ap_exp_no_side_effect: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_exp_code == isa_exp_ext_int || ex_exp_code == isa_exp_overflow) |->
		(ex_gpr_we_ == gpr_we_off && ex_mem_op == mem_op_nop))
		else $error("ex_reg: excepted slot keeps side effects");

	// back-pressure from mem holds the whole register
	ap_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable({ex_pc, ex_en, ex_br_flag, ex_mem_op, ex_mem_wr_data,
		ex_ctrl_op, ex_dst_addr, ex_gpr_we_, ex_exp_code, ex_out}))
		else $error("ex_reg: outputs changed under stall");

endmodule

//--- design/ex_stage.sv
`timescale 1ns/10ps

module ex_stage
	import cpu_pkg::*;
	import isa_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	// pipeline control
	input  logic                   stall,
	input  logic                   flush,
	input  logic                   int_detect,
	// operands from id
	input  logic [alu_op_w-1:0]    id_alu_op,
	input  logic [word_data_w-1:0] id_alu_in_0,
	input  logic [word_data_w-1:0] id_alu_in_1,
	// id/ex fields
	input  logic [word_addr_w-1:0] id_pc,
	input  logic                   id_en,
	input  logic                   id_br_flag,
	input  logic [mem_op_w-1:0]    id_mem_op,
	input  logic [word_data_w-1:0] id_mem_wr_data,
	input  logic [ctrl_op_w-1:0]   id_ctrl_op,
	input  logic [reg_addr_w-1:0]  id_dst_addr,
	input  logic                   id_gpr_we_,
	input  logic [isa_exp_w-1:0]   id_exp_code,
	// forwarding path back to id
	output logic [word_data_w-1:0] ex_fwd_data,
	// ex/mem fields
	output logic [word_addr_w-1:0] ex_pc,
	output logic                   ex_en,
	output logic                   ex_br_flag,
	output logic [mem_op_w-1:0]    ex_mem_op,
	output logic [word_data_w-1:0] ex_mem_wr_data,
	output logic [ctrl_op_w-1:0]   ex_ctrl_op,
	output logic [reg_addr_w-1:0]  ex_dst_addr,
	output logic                   ex_gpr_we_,
	output logic [isa_exp_w-1:0]   ex_exp_code,
	output logic [word_data_w-1:0] ex_out
);

	logic [word_data_w-1:0] alu_out;
	logic                   alu_of;

	assign ex_fwd_data = alu_out; // same-cycle bypass, not registered

	alu i_alu (
		.op   (id_alu_op),
		.in_0 (id_alu_in_0),
		.in_1 (id_alu_in_1),
		.out  (alu_out),
		.of   (alu_of)
	);

	ex_reg i_ex_reg (
		.clk            (clk),
		.rst_n          (rst_n),
		.alu_out        (alu_out),
		.alu_of         (alu_of),
		.stall          (stall),
		.flush          (flush),
		.int_detect     (int_detect),
		.id_pc          (id_pc),
		.id_en          (id_en),
		.id_br_flag     (id_br_flag),
		.id_mem_op      (id_mem_op),
		.id_mem_wr_data (id_mem_wr_data),
		.id_ctrl_op     (id_ctrl_op),
		.id_dst_addr    (id_dst_addr),
		.id_gpr_we_     (id_gpr_we_),
		.id_exp_code    (id_exp_code),
		.ex_pc          (ex_pc),
		.ex_en          (ex_en),
		.ex_br_flag     (ex_br_flag),
		.ex_mem_op      (ex_mem_op),
		.ex_mem_wr_data (ex_mem_wr_data),
		.ex_ctrl_op     (ex_ctrl_op),
		.ex_dst_addr    (ex_dst_addr),
		.ex_gpr_we_     (ex_gpr_we_),
		.ex_exp_code    (ex_exp_code),
		.ex_out         (ex_out)
	);

endmodule

//--- design/isa_pkg.sv
package isa_pkg;

	// alu operation codes
	localparam int alu_op_w = 4;

	localparam logic [alu_op_w-1:0] alu_op_nop  = 4'h0; // pass in_0
	localparam logic [alu_op_w-1:0] alu_op_and  = 4'h1;
	localparam logic [alu_op_w-1:0] alu_op_or   = 4'h2;
	localparam logic [alu_op_w-1:0] alu_op_xor  = 4'h3;
	localparam logic [alu_op_w-1:0] alu_op_adds = 4'h4; // signed, can overflow
	localparam logic [alu_op_w-1:0] alu_op_addu = 4'h5;
	localparam logic [alu_op_w-1:0] alu_op_subs = 4'h6; // signed, can overflow
	localparam logic [alu_op_w-1:0] alu_op_subu = 4'h7;
	localparam logic [alu_op_w-1:0] alu_op_shrl = 4'h8;
	localparam logic [alu_op_w-1:0] alu_op_shll = 4'h9;
	localparam logic [alu_op_w-1:0] alu_op_shra = 4'ha;

	// shift amount comes from the low bits of in_1
	localparam int alu_shamt_w = 5;

	// memory operations
	localparam int mem_op_w = 2;

	localparam logic [mem_op_w-1:0] mem_op_nop = 2'h0;
	localparam logic [mem_op_w-1:0] mem_op_ldw = 2'h1; // load word
	localparam logic [mem_op_w-1:0] mem_op_stw = 2'h2; // store word

	// control register operations
	localparam int ctrl_op_w = 2;

	localparam logic [ctrl_op_w-1:0] ctrl_op_nop  = 2'h0;
	localparam logic [ctrl_op_w-1:0] ctrl_op_wrcr = 2'h1; // write control reg
	localparam logic [ctrl_op_w-1:0] ctrl_op_exrt = 2'h2; // return from exception

	// exception codes
	localparam int isa_exp_w = 3;

	localparam logic [isa_exp_w-1:0] isa_exp_no_exp     = 3'h0;
	localparam logic [isa_exp_w-1:0] isa_exp_ext_int    = 3'h1; // external interrupt
	localparam logic [isa_exp_w-1:0] isa_exp_undef_insn = 3'h2;
	localparam logic [isa_exp_w-1:0] isa_exp_overflow   = 3'h3; // signed arith overflow
	localparam logic [isa_exp_w-1:0] isa_exp_misalign   = 3'h4;
	localparam logic [isa_exp_w-1:0] isa_exp_trap       = 3'h5;

endpackage

//--- run.sh
#!/bin/sh
# build and run the execute-stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module ex_stage_tb -o ex_stage_sim &&
./obj_dir/ex_stage_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }

//--- sim.f
design/isa_pkg.sv
design/cpu_pkg.sv
design/alu.sv
design/ex_reg.sv
design/ex_stage.sv
test/ex_stage_tb.sv

//--- test/ex_stage_tb.sv
`timescale 1ns/10ps

module ex_stage_tb
	import cpu_pkg::*;
	import isa_pkg::*;
;

	localparam int n_fixed = 22;
	localparam int n_rand  = 4;
	localparam int n_rows  = n_fixed + n_rand;
	localparam int clk_period = 100;

	typedef struct packed {
		logic                   st, fl, intd;
		logic [alu_op_w-1:0]    op;
		logic [word_data_w-1:0] a, b, alu; // operands and expected alu result
		logic                   of;        // expected overflow
		logic [word_addr_w-1:0] pc;
		logic                   en, br, we_;
		logic [mem_op_w-1:0]    mem;
		logic [ctrl_op_w-1:0]   ctrl;
		logic [word_data_w-1:0] wd;
		logic [reg_addr_w-1:0]  dst;
		logic [isa_exp_w-1:0]   exc;
	} row_t;

	logic clk = 1'b0;
	logic rst_n, stall, flush, int_detect;
	logic [alu_op_w-1:0]    id_alu_op;
	logic [word_data_w-1:0] id_alu_in_0, id_alu_in_1, id_mem_wr_data;
	logic [word_addr_w-1:0] id_pc;
	logic                   id_en, id_br_flag, id_gpr_we_;
	logic [mem_op_w-1:0]    id_mem_op;
	logic [ctrl_op_w-1:0]   id_ctrl_op;
	logic [reg_addr_w-1:0]  id_dst_addr;
	logic [isa_exp_w-1:0]   id_exp_code;
	logic [word_data_w-1:0] ex_fwd_data, ex_mem_wr_data, ex_out;
	logic [word_addr_w-1:0] ex_pc;
	logic                   ex_en, ex_br_flag, ex_gpr_we_;
	logic [mem_op_w-1:0]    ex_mem_op;
	logic [ctrl_op_w-1:0]   ex_ctrl_op;
	logic [reg_addr_w-1:0]  ex_dst_addr;
	logic [isa_exp_w-1:0]   ex_exp_code;

	row_t rows [n_rows];
	row_t expd; // expected register contents, same field layout
	int   n_added = 0;
	int   errors  = 0;

	ex_stage i_dut (.*);

	always #(clk_period/2) clk = ~clk;

	task automatic add_row(input logic st, input logic fl, input logic intd,
		input logic [alu_op_w-1:0] op, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] alu, input logic of);
		row_t r;
		int   i;
		i = n_added;
		{r.st, r.fl, r.intd} = {st, fl, intd};
		{r.op, r.a, r.b, r.alu, r.of} = {op, a, b, alu, of};
		r.pc   = 30'h100 + i; // id fields follow the row index
		r.en   = (i % 4) != 1; // some bubbles ride along too
		r.br   = i[0];
		r.we_  = i[2];
		r.mem  = mem_op_w'(i % 3);
		r.ctrl = ctrl_op_w'(i[1]);
		r.wd   = {i[7:0], 24'ha5c3e1};
		r.dst  = i[4:0];
		r.exc  = (i == 3) ? isa_exp_undef_insn : isa_exp_no_exp;
		rows[i] = r;
		n_added++;
	endtask

	// next register contents from the stage priority rules
	task automatic predict(input row_t r);
		if (r.st) begin
			// hold
		end else if (r.fl) begin
			expd = '0;
			expd.we_ = 1'b1;
		end else if (r.intd || r.of) begin
			expd = '0;
			expd.pc  = r.pc;
			expd.en  = r.en;
			expd.br  = r.br;
			expd.we_ = 1'b1;
			expd.exc = r.intd ? isa_exp_ext_int : isa_exp_overflow;
		end else begin
			expd = r; // alu field doubles as expected ex_out
		end
	endtask

	task automatic check(input string name, input logic [31:0] want, input logic [31:0] got);
		if (want !== got) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, want, got);
			errors++;
		end
	endtask

	task automatic check_outputs();
		check("ex_pc", 32'(expd.pc), 32'(ex_pc));
		check("ex_en", 32'(expd.en), 32'(ex_en));
		check("ex_br_flag", 32'(expd.br), 32'(ex_br_flag));
		check("ex_mem_op", 32'(expd.mem), 32'(ex_mem_op));
		check("ex_mem_wr_data", expd.wd, ex_mem_wr_data);
		check("ex_ctrl_op", 32'(expd.ctrl), 32'(ex_ctrl_op));
		check("ex_dst_addr", 32'(expd.dst), 32'(ex_dst_addr));
		check("ex_gpr_we_", 32'(expd.we_), 32'(ex_gpr_we_));
		check("ex_exp_code", 32'(expd.exc), 32'(ex_exp_code));
		check("ex_out", expd.alu, ex_out);
	endtask

	task automatic drive_row(input row_t r);
		{stall, flush, int_detect} <= {r.st, r.fl, r.intd};
		{id_alu_op, id_alu_in_0, id_alu_in_1} <= {r.op, r.a, r.b};
		{id_pc, id_en, id_br_flag} <= {r.pc, r.en, r.br};
		{id_mem_op, id_mem_wr_data, id_ctrl_op} <= {r.mem, r.wd, r.ctrl};
		{id_dst_addr, id_gpr_we_, id_exp_code} <= {r.dst, r.we_, r.exc};
	endtask

	initial begin
		logic [31:0] ra, rb;
		void'($urandom(77894));
		rst_n = 1'b0;
		{stall, flush, int_detect} = 3'b000;
		{id_alu_op, id_alu_in_0, id_alu_in_1} = {alu_op_nop, 64'h0};
		{id_pc, id_en, id_br_flag} = {word_addr_zero, slot_dis, br_none};
		{id_mem_op, id_mem_wr_data, id_ctrl_op} = {mem_op_nop, word_data_zero, ctrl_op_nop};
		{id_dst_addr, id_gpr_we_, id_exp_code} = {reg_addr_zero, 1'b1, isa_exp_no_exp};

		add_row(0, 0, 0, alu_op_nop,  32'h12345678, 32'h0,        32'h12345678, 0);
		add_row(0, 0, 0, alu_op_and,  32'hf0f0f0f0, 32'h0ff00ff0, 32'h00f000f0, 0);
		add_row(0, 0, 0, alu_op_or,   32'hf0f0f0f0, 32'h0ff00ff0, 32'hfff0fff0, 0);
		add_row(0, 0, 0, alu_op_xor,  32'hf0f0f0f0, 32'h0ff00ff0, 32'hff00ff00, 0);
		add_row(0, 0, 0, alu_op_adds, 32'd5,        32'd7,        32'd12,       0);
		add_row(0, 0, 0, alu_op_addu, 32'hffffffff, 32'd1,        32'h0,        0);
		add_row(0, 0, 0, alu_op_subs, 32'd10,       32'd3,        32'd7,        0);
		add_row(0, 0, 0, alu_op_subu, 32'd3,        32'd10,       32'hfffffff9, 0);
		add_row(0, 0, 0, alu_op_shrl, 32'h80000010, 32'd4,        32'h08000001, 0);
		add_row(0, 0, 0, alu_op_shll, 32'h80000010, 32'd4,        32'h00000100, 0);
		add_row(0, 0, 0, alu_op_shra, 32'h80000010, 32'd4,        32'hf8000001, 0);
		add_row(0, 0, 0, alu_op_shra, 32'hf0000000, 32'h24,       32'hff000000, 0); // b above 31
		add_row(0, 0, 0, alu_op_adds, 32'h7fffffff, 32'd1,        32'h80000000, 1);
		add_row(0, 0, 0, alu_op_addu, 32'h7fffffff, 32'd1,        32'h80000000, 0);
		add_row(0, 0, 0, alu_op_subs, 32'h80000000, 32'd1,        32'h7fffffff, 1);
		add_row(0, 0, 0, alu_op_subu, 32'h80000000, 32'd1,        32'h7fffffff, 0);
		add_row(0, 0, 1, alu_op_addu, 32'd1,        32'd2,        32'd3,        0);
		add_row(0, 0, 1, alu_op_adds, 32'h7fffffff, 32'd1,        32'h80000000, 1); // int wins
		add_row(0, 1, 1, alu_op_or,   32'h0000ff00, 32'h000000ff, 32'h0000ffff, 0);
		add_row(0, 0, 0, alu_op_xor,  32'haaaa5555, 32'hffffffff, 32'h5555aaaa, 0);
		add_row(1, 0, 1, alu_op_adds, 32'h7fffffff, 32'd1,        32'h80000000, 1);
		add_row(1, 1, 0, alu_op_and,  32'h13572468, 32'hffff0000, 32'h13570000, 0);
		for (int k = 0; k < n_rand; k++) begin
			ra = $urandom();
			rb = $urandom();
			if (k[0])
				add_row(0, 0, 0, alu_op_xor, ra, rb, ra ^ rb, 0);
			else
				add_row(0, 0, 0, alu_op_addu, ra, rb, ra + rb, 0);
			rows[n_added-1].wd = $urandom();
		end

		expd = '0;
		expd.we_ = 1'b1;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_outputs(); // reset values

		for (int i = 0; i < n_rows; i++) begin
			@(posedge clk);
			drive_row(rows[i]);
			@(negedge clk);
			if (i > 0)
				check_outputs(); // row i-1 was captured at this edge
			check("ex_fwd_data", rows[i].alu, ex_fwd_data);
			predict(rows[i]);
		end
		@(posedge clk);
		@(negedge clk);
		check_outputs();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#((16 + 2 * n_rows + 10) * clk_period);
		$display("timeout: the test sequence did not finish in time");
		$display("Test failed");
		$finish;
	end

endmodule
